//--- src/vregpack_cfg_pkg.sv
// Sizes and index types of the register write port, register addresses
// and instruction IDs. Shared by all blocks of the result packing stage.
`default_nettype none

package vregpack_cfg_pkg;

    // register port and result widths
    localparam int unsigned VPORT_W        = 128;
    localparam int unsigned RES_W          = 32;
    localparam int unsigned NARROW_W       = 16;   // narrow result, half a word

    // register file addressing
    localparam int unsigned VADDR_W        = 5;
    localparam int unsigned VREG_CNT       = 32;   // 2**VADDR_W

    // instruction IDs
    localparam int unsigned INSTR_ID_W     = 3;
    localparam int unsigned INSTR_ID_CNT   = 8;

    // pending clear count, spans up to 8 registers
    localparam int unsigned PEND_CLR_CNT_W = 2;

    typedef logic [VPORT_W-1:0]        vport_data_t;
    typedef logic [VPORT_W/8-1:0]      vport_be_t;
    typedef logic [RES_W-1:0]          res_data_t;
    typedef logic [RES_W/8-1:0]        res_be_t;
    typedef logic [VADDR_W-1:0]        vaddr_t;
    typedef logic [VREG_CNT-1:0]       vreg_mask_t;   // one bit per register
    typedef logic [INSTR_ID_W-1:0]     instr_id_t;
    typedef logic [INSTR_ID_CNT-1:0]   instr_mask_t;  // one bit per ID
    typedef logic [PEND_CLR_CNT_W-1:0] pend_clr_cnt_t;

endpackage

`default_nettype wire

//--- src/vregpack_op_pkg.sv
// Packing operations and the stage state encoding.
// Used by the RTL blocks and by the checker.
`default_nettype none

package vregpack_op_pkg;

    // how a result enters the shift buffer
    typedef enum logic [1:0] {
        PACK_FULL         = 2'd0,  // shift down one word, result into top word
        PACK_NARROW_HOLD  = 2'd1,  // half result into top word, lower part kept
        PACK_NARROW_SHIFT = 2'd2,  // half result into top word, lower part shifted
        PACK_NONE         = 2'd3   // buffer untouched
    } pack_op_e;

    // occupancy of the single pipeline stage
    typedef enum logic {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL  = 1'b1
    } stage_state_e;

endpackage

`default_nettype wire

//--- src/vregpack_shift_buffer.sv
// Register-wide data and byte-mask buffer that results are shifted into.
// Loaded once per accepted result; the stage decides when to load.
`timescale 1ns/10ps
`default_nettype none

module vregpack_shift_buffer (
    input  wire logic                           clk_i,
    input  wire logic                           async_rst_ni,
    input  wire logic                           load_i,
    input  wire vregpack_op_pkg::pack_op_e      op_i,
    input  wire vregpack_cfg_pkg::res_data_t    res_data_i,
    input  wire vregpack_cfg_pkg::res_be_t      res_be_i,
    output vregpack_cfg_pkg::vport_data_t       buf_data_o,
    output vregpack_cfg_pkg::vport_be_t         buf_be_o
);

    vregpack_cfg_pkg::vport_data_t data_q, data_d;
    vregpack_cfg_pkg::vport_be_t   be_q, be_d;

    // next buffer contents for each packing rule
    always_comb begin
        data_d = data_q;
        be_d   = be_q;
        unique case (op_i)
            vregpack_op_pkg::PACK_FULL: begin
                // whole word in at the top, everything moves down one word
                data_d = {res_data_i,
                          data_q[vregpack_cfg_pkg::VPORT_W-1:vregpack_cfg_pkg::RES_W]};
                be_d   = {res_be_i,
                          be_q[vregpack_cfg_pkg::VPORT_W/8-1:vregpack_cfg_pkg::RES_W/8]};
            end
            vregpack_op_pkg::PACK_NARROW_HOLD,
            vregpack_op_pkg::PACK_NARROW_SHIFT: begin
                // new half above the old upper half of the top word
                data_d[vregpack_cfg_pkg::VPORT_W-1 -: vregpack_cfg_pkg::RES_W] = {
                    res_data_i[vregpack_cfg_pkg::NARROW_W-1:0],
                    data_q[vregpack_cfg_pkg::VPORT_W-1 -: vregpack_cfg_pkg::NARROW_W]
                };
                be_d[vregpack_cfg_pkg::VPORT_W/8-1 -: vregpack_cfg_pkg::RES_W/8] = {
                    res_be_i[vregpack_cfg_pkg::NARROW_W/8-1:0],
                    be_q[vregpack_cfg_pkg::VPORT_W/8-1 -: vregpack_cfg_pkg::NARROW_W/8]
                };
                if (op_i == vregpack_op_pkg::PACK_NARROW_SHIFT) begin
                    // lower 96 bits take the old upper 96 bits
                    data_d[vregpack_cfg_pkg::VPORT_W-vregpack_cfg_pkg::RES_W-1:0] =
                        data_q[vregpack_cfg_pkg::VPORT_W-1:vregpack_cfg_pkg::RES_W];
                    be_d[vregpack_cfg_pkg::VPORT_W/8-vregpack_cfg_pkg::RES_W/8-1:0] =
                        be_q[vregpack_cfg_pkg::VPORT_W/8-1:vregpack_cfg_pkg::RES_W/8];
                end
            end
            default: ;  // PACK_NONE keeps the buffer
        endcase
    end

    // buffer starts empty, all bytes disabled
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            data_q <= '0;
            be_q   <= '0;
        end else if (load_i) begin
            data_q <= data_d;
            be_q   <= be_d;
        end
    end

    assign buf_data_o = data_q;
    assign buf_be_o   = be_q;

endmodule

`default_nettype wire

//--- src/vregpack_stage.sv
// Single pipeline stage holding the control fields of one result item.
// Decides stall, kill, input ready, retirement and the done strobe.
`timescale 1ns/10ps
`default_nettype none

module vregpack_stage (
    input  wire logic                               clk_i,
    input  wire logic                               async_rst_ni,
    input  wire logic                               pipe_in_valid_i,
    input  wire vregpack_cfg_pkg::instr_id_t        pipe_in_instr_id_i,
    input  wire vregpack_cfg_pkg::vaddr_t           pipe_in_vaddr_i,
    input  wire logic                               pipe_in_res_valid_i,
    input  wire vregpack_op_pkg::pack_op_e          pipe_in_op_i,
    input  wire logic                               pipe_in_res_store_i,
    input  wire logic                               pipe_in_pend_clr_i,
    input  wire vregpack_cfg_pkg::pend_clr_cnt_t    pipe_in_pend_clr_cnt_i,
    input  wire logic                               pipe_in_instr_done_i,
    input  wire vregpack_cfg_pkg::vreg_mask_t       pending_vreg_reads_i,
    input  wire vregpack_cfg_pkg::instr_mask_t      instr_spec_i,
    input  wire vregpack_cfg_pkg::instr_mask_t      instr_killed_i,
    input  wire logic                               vreg_wr_ready_i,
    output logic                                    pipe_in_ready_o,
    output logic                                    buf_load_o,
    output logic                                    wr_req_o,
    output logic                                    retire_o,
    output vregpack_cfg_pkg::vaddr_t                vaddr_o,
    output logic                                    pend_clr_o,
    output vregpack_cfg_pkg::pend_clr_cnt_t         pend_clr_cnt_o,
    output logic                                    instr_done_valid_o,
    output vregpack_cfg_pkg::instr_id_t             instr_done_id_o
);

    vregpack_op_pkg::stage_state_e   state_q, state_d;
    logic                            in_en_q;        // set once reset has been released
    vregpack_cfg_pkg::instr_id_t     instr_id_q;
    vregpack_cfg_pkg::vaddr_t        vaddr_q;
    logic                            store_q;
    logic                            pend_clr_q;
    vregpack_cfg_pkg::pend_clr_cnt_t pend_clr_cnt_q;
    logic                            instr_done_q;

    logic full, stall, killed, accept;

    assign full   = (state_q == vregpack_op_pkg::STAGE_FULL);
    // a store waits for the destination's readers and for the ID to turn non-speculative
    assign stall  = store_q & (pending_vreg_reads_i[vaddr_q] | instr_spec_i[instr_id_q]);
    assign killed = instr_killed_i[instr_id_q];

    assign wr_req_o        = full & store_q & ~stall & ~killed;
    assign retire_o        = full & ~stall & (~store_q | killed | vreg_wr_ready_i);
    assign pipe_in_ready_o = in_en_q & (~full | retire_o);
    assign accept          = pipe_in_valid_i & pipe_in_ready_o;

    // results with PACK_NONE leave the buffer alone anyway
    assign buf_load_o = accept & pipe_in_res_valid_i &
                        (pipe_in_op_i != vregpack_op_pkg::PACK_NONE);

    always_comb begin
        state_d = state_q;
        if (accept) begin
            state_d = vregpack_op_pkg::STAGE_FULL;  // refill in the retiring cycle too
        end else if (retire_o) begin
            state_d = vregpack_op_pkg::STAGE_EMPTY;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q        <= vregpack_op_pkg::STAGE_EMPTY;
            in_en_q        <= 1'b0;
            instr_id_q     <= '0;
            vaddr_q        <= '0;
            store_q        <= 1'b0;
            pend_clr_q     <= 1'b0;
            pend_clr_cnt_q <= '0;
            instr_done_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            in_en_q <= 1'b1;
            if (accept) begin
                instr_id_q     <= pipe_in_instr_id_i;
                vaddr_q        <= pipe_in_vaddr_i;
                store_q        <= pipe_in_res_store_i;
                pend_clr_q     <= pipe_in_pend_clr_i;
                pend_clr_cnt_q <= pipe_in_pend_clr_cnt_i;
                instr_done_q   <= pipe_in_instr_done_i;
            end
        end
    end

    assign vaddr_o        = vaddr_q;
    assign pend_clr_o     = full & pend_clr_q;
    assign pend_clr_cnt_o = pend_clr_cnt_q;

    // done fires when the item leaves, killed or not
    assign instr_done_valid_o = retire_o & instr_done_q;
    assign instr_done_id_o    = instr_id_q;

endmodule

`default_nettype wire

//--- src/vregpack_wr_port.sv
// Register file write port and the registered pending-write clear mask.
// Driven by the stage's write request and retire signals.
`timescale 1ns/10ps
`default_nettype none

module vregpack_wr_port (
    input  wire logic                               clk_i,
    input  wire logic                               async_rst_ni,
    input  wire logic                               wr_req_i,
    input  wire logic                               retire_i,
    input  wire vregpack_cfg_pkg::vaddr_t           vaddr_i,
    input  wire logic                               pend_clr_i,
    input  wire vregpack_cfg_pkg::pend_clr_cnt_t    pend_clr_cnt_i,
    input  wire vregpack_cfg_pkg::vport_data_t      buf_data_i,
    input  wire vregpack_cfg_pkg::vport_be_t        buf_be_i,
    output logic                                    vreg_wr_valid_o,
    output vregpack_cfg_pkg::vaddr_t                vreg_wr_addr_o,
    output vregpack_cfg_pkg::vport_be_t             vreg_wr_be_o,
    output vregpack_cfg_pkg::vport_data_t           vreg_wr_data_o,
    output vregpack_cfg_pkg::vreg_mask_t            clear_pending_vreg_writes_o
);

    vregpack_cfg_pkg::vaddr_t     grp_mask;   // address bits that select the group
    vregpack_cfg_pkg::vreg_mask_t clr_d, clr_q;

    // write payload is zero whenever nothing is written
    assign vreg_wr_valid_o = wr_req_i;
    assign vreg_wr_addr_o  = wr_req_i ? vaddr_i    : '0;
    assign vreg_wr_be_o    = wr_req_i ? buf_be_i   : '0;
    assign vreg_wr_data_o  = wr_req_i ? buf_data_i : '0;

    // count c ignores the low c address bits, i.e. an aligned group of 2**c registers
    assign grp_mask = {vregpack_cfg_pkg::VADDR_W{1'b1}} << pend_clr_cnt_i;

    always_comb begin
        clr_d = '0;
        if (retire_i && pend_clr_i) begin
            for (int i = 0; i < vregpack_cfg_pkg::VREG_CNT; i++) begin
                clr_d[i] = ((vregpack_cfg_pkg::VADDR_W'(i) & grp_mask) ==
                            (vaddr_i & grp_mask));
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            clr_q <= '0;
        end else begin
            clr_q <= clr_d;  // one-cycle pulse after retirement
        end
    end

    assign clear_pending_vreg_writes_o = clr_q;

endmodule

`default_nettype wire

//--- src/vregpack_top.sv
// Top level of the result packing stage.
// Connects stage, shift buffer and write port to the outside ports.
`timescale 1ns/10ps
`default_nettype none

module vregpack_top (
    input  wire logic                               clk_i,
    input  wire logic                               async_rst_ni,

    // pipeline in
    input  wire logic                               pipe_in_valid_i,
    output logic                                    pipe_in_ready_o,
    input  wire vregpack_cfg_pkg::instr_id_t        pipe_in_instr_id_i,
    input  wire vregpack_cfg_pkg::vaddr_t           pipe_in_vaddr_i,
    input  wire logic                               pipe_in_res_valid_i,
    input  wire vregpack_op_pkg::pack_op_e          pipe_in_op_i,
    input  wire logic                               pipe_in_res_store_i,
    input  wire logic                               pipe_in_pend_clr_i,
    input  wire vregpack_cfg_pkg::pend_clr_cnt_t    pipe_in_pend_clr_cnt_i,
    input  wire logic                               pipe_in_instr_done_i,
    input  wire vregpack_cfg_pkg::res_data_t        res_data_i,
    input  wire vregpack_cfg_pkg::res_be_t          res_be_i,

    // hazard and speculation state
    input  wire vregpack_cfg_pkg::vreg_mask_t       pending_vreg_reads_i,
    input  wire vregpack_cfg_pkg::instr_mask_t      instr_spec_i,
    input  wire vregpack_cfg_pkg::instr_mask_t      instr_killed_i,

    // register file write port
    output logic                                    vreg_wr_valid_o,
    input  wire logic                               vreg_wr_ready_i,
    output vregpack_cfg_pkg::vaddr_t                vreg_wr_addr_o,
    output vregpack_cfg_pkg::vport_be_t             vreg_wr_be_o,
    output vregpack_cfg_pkg::vport_data_t           vreg_wr_data_o,
    output vregpack_cfg_pkg::vreg_mask_t            clear_pending_vreg_writes_o,

    // instruction done
    output logic                                    instr_done_valid_o,
    output vregpack_cfg_pkg::instr_id_t             instr_done_id_o
);

    logic                            buf_load;
    logic                            wr_req;
    logic                            retire;
    logic                            pend_clr;
    vregpack_cfg_pkg::vaddr_t        vaddr;
    vregpack_cfg_pkg::pend_clr_cnt_t pend_clr_cnt;
    vregpack_cfg_pkg::vport_data_t   buf_data;
    vregpack_cfg_pkg::vport_be_t     buf_be;

    vregpack_stage u_stage (
        .clk_i                  (clk_i),
        .async_rst_ni           (async_rst_ni),
        .pipe_in_valid_i        (pipe_in_valid_i),
        .pipe_in_instr_id_i     (pipe_in_instr_id_i),
        .pipe_in_vaddr_i        (pipe_in_vaddr_i),
        .pipe_in_res_valid_i    (pipe_in_res_valid_i),
        .pipe_in_op_i           (pipe_in_op_i),
        .pipe_in_res_store_i    (pipe_in_res_store_i),
        .pipe_in_pend_clr_i     (pipe_in_pend_clr_i),
        .pipe_in_pend_clr_cnt_i (pipe_in_pend_clr_cnt_i),
        .pipe_in_instr_done_i   (pipe_in_instr_done_i),
        .pending_vreg_reads_i   (pending_vreg_reads_i),
        .instr_spec_i           (instr_spec_i),
        .instr_killed_i         (instr_killed_i),
        .vreg_wr_ready_i        (vreg_wr_ready_i),
        .pipe_in_ready_o        (pipe_in_ready_o),
        .buf_load_o             (buf_load),
        .wr_req_o               (wr_req),
        .retire_o               (retire),
        .vaddr_o                (vaddr),
        .pend_clr_o             (pend_clr),
        .pend_clr_cnt_o         (pend_clr_cnt),
        .instr_done_valid_o     (instr_done_valid_o),
        .instr_done_id_o        (instr_done_id_o)
    );

    vregpack_shift_buffer u_shift_buffer (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .load_i       (buf_load),
        .op_i         (pipe_in_op_i),
        .res_data_i   (res_data_i),
        .res_be_i     (res_be_i),
        .buf_data_o   (buf_data),
        .buf_be_o     (buf_be)
    );

    vregpack_wr_port u_wr_port (
        .clk_i                       (clk_i),
        .async_rst_ni                (async_rst_ni),
        .wr_req_i                    (wr_req),
        .retire_i                    (retire),
        .vaddr_i                     (vaddr),
        .pend_clr_i                  (pend_clr),
        .pend_clr_cnt_i              (pend_clr_cnt),
        .buf_data_i                  (buf_data),
        .buf_be_i                    (buf_be),
        .vreg_wr_valid_o             (vreg_wr_valid_o),
        .vreg_wr_addr_o              (vreg_wr_addr_o),
        .vreg_wr_be_o                (vreg_wr_be_o),
        .vreg_wr_data_o              (vreg_wr_data_o),
        .clear_pending_vreg_writes_o (clear_pending_vreg_writes_o)
    );

endmodule

`default_nettype wire

//--- sim/vregpack_checker.sv
// Handshake and reset assertions for the packing stage.
// Attached to vregpack_top by the bind at the end of this file.
`timescale 1ns/10ps
`default_nettype none

module vregpack_checker (
    input wire logic                           clk_i,
    input wire logic                           async_rst_ni,
    input wire logic                           retire_i,
    input wire logic                           pend_clr_i,
    input wire vregpack_op_pkg::stage_state_e  state_i,
    input wire logic                           pipe_in_valid_i,
    input wire logic                           pipe_in_ready_i,
    input wire logic                           wr_valid_i,
    input wire logic                           wr_ready_i,
    input wire vregpack_cfg_pkg::vaddr_t       wr_addr_i,
    input wire vregpack_cfg_pkg::vport_be_t    wr_be_i,
    input wire vregpack_cfg_pkg::vport_data_t  wr_data_i,
    input wire logic                           done_valid_i,
    input wire vregpack_cfg_pkg::vreg_mask_t   clr_mask_i
);

    int fail_cnt = 0;  // failed assertions so far

    // write request holds until the register file takes it
    wr_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_addr_i) &&
        $stable(wr_be_i) && $stable(wr_data_i))
        else begin $error("write payload changed under back-pressure"); fail_cnt++; end

    // without a refill the stage empties, so done cannot repeat
    done_pulse: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        done_valid_i && !(pipe_in_valid_i && pipe_in_ready_i) |=>
        !done_valid_i && state_i == vregpack_op_pkg::STAGE_EMPTY)
        else begin $error("done strobe held after its item retired"); fail_cnt++; end

    // the group always holds the item's own register, so the mask is never empty
    clr_after_retire: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (|clr_mask_i) == $past(retire_i && pend_clr_i))
        else begin $error("clear mask outside the cycle after retirement"); fail_cnt++; end

    reset_quiet: assert property (@(posedge clk_i)
        !async_rst_ni |-> !wr_valid_i && !done_valid_i && !pipe_in_ready_i && clr_mask_i == '0)
        else begin $error("outputs active during reset"); fail_cnt++; end

endmodule

bind vregpack_top vregpack_checker u_checker (
    .clk_i           (clk_i),
    .async_rst_ni    (async_rst_ni),
    .retire_i        (retire),
    .pend_clr_i      (pend_clr),
    .state_i         (u_stage.state_q),
    .pipe_in_valid_i (pipe_in_valid_i),
    .pipe_in_ready_i (pipe_in_ready_o),
    .wr_valid_i      (vreg_wr_valid_o),
    .wr_ready_i      (vreg_wr_ready_i),
    .wr_addr_i       (vreg_wr_addr_o),
    .wr_be_i         (vreg_wr_be_o),
    .wr_data_i       (vreg_wr_data_o),
    .done_valid_i    (instr_done_valid_o),
    .clr_mask_i      (clear_pending_vreg_writes_o)
);

`default_nettype wire

//--- sim/vregpack_tb.sv
// Directed testbench for the result packing stage.
// Feeds results through the pipeline input and checks writes, done and clear mask.
`timescale 1ns/10ps
`default_nettype none

module vregpack_tb;

    logic clk_i = 1'b0;
    logic async_rst_ni;
    logic pipe_in_valid_i, pipe_in_ready_o, pipe_in_res_valid_i, pipe_in_res_store_i;
    logic pipe_in_pend_clr_i, pipe_in_instr_done_i, vreg_wr_valid_o, vreg_wr_ready_i;
    logic instr_done_valid_o;
    vregpack_cfg_pkg::instr_id_t     pipe_in_instr_id_i, instr_done_id_o;
    vregpack_cfg_pkg::vaddr_t        pipe_in_vaddr_i, vreg_wr_addr_o;
    vregpack_op_pkg::pack_op_e       pipe_in_op_i;
    vregpack_cfg_pkg::pend_clr_cnt_t pipe_in_pend_clr_cnt_i;
    vregpack_cfg_pkg::res_data_t     res_data_i;
    vregpack_cfg_pkg::res_be_t       res_be_i;
    vregpack_cfg_pkg::vreg_mask_t    pending_vreg_reads_i, clear_pending_vreg_writes_o;
    vregpack_cfg_pkg::instr_mask_t   instr_spec_i, instr_killed_i;
    vregpack_cfg_pkg::vport_be_t     vreg_wr_be_o, exp_be;    // exp_* is the packing model
    vregpack_cfg_pkg::vport_data_t   vreg_wr_data_o, exp_data;
    int err_cnt, test_cnt, wr_cnt, done_cnt, e0;

    always #2 clk_i = ~clk_i;

    vregpack_top UUT (.*);

    // counted mid-cycle, the transfer itself happens on the next rising edge
    always @(negedge clk_i) begin
        if (vreg_wr_valid_o && vreg_wr_ready_i) wr_cnt++;
        if (instr_done_valid_o) done_cnt++;
    end

    task automatic check_data(string sig, vregpack_cfg_pkg::vport_data_t expv, actv);
        if (expv !== actv) begin
            $display("[ERROR] %s expected %h actual %h", sig, expv, actv);
            err_cnt++;
        end
    endtask

    task automatic check_be(string sig, vregpack_cfg_pkg::vport_be_t expv, actv);
        if (expv !== actv) begin
            $display("[ERROR] %s expected %h actual %h", sig, expv, actv);
            err_cnt++;
        end
    endtask

    task automatic check_mask(string sig, vregpack_cfg_pkg::vreg_mask_t expv, actv);
        if (expv !== actv) begin
            $display("[ERROR] %s expected %h actual %h", sig, expv, actv);
            err_cnt++;
        end
    endtask

    task automatic check_id(string sig, vregpack_cfg_pkg::instr_id_t expv, actv);
        if (expv !== actv) begin
            $display("[ERROR] %s expected %h actual %h", sig, expv, actv);
            err_cnt++;
        end
    endtask

    task automatic check_addr(string sig, vregpack_cfg_pkg::vaddr_t expv, actv);
        if (expv !== actv) begin
            $display("[ERROR] %s expected %h actual %h", sig, expv, actv);
            err_cnt++;
        end
    endtask

    task automatic report_fault(string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    // reference packing, word and byte lanes numbered from the top of the register
    task automatic pack_model(vregpack_op_pkg::pack_op_e op, vregpack_cfg_pkg::res_data_t d,
                              vregpack_cfg_pkg::res_be_t be);
        case (op)
            vregpack_op_pkg::PACK_FULL: begin
                exp_data = {d, exp_data[127:32]};
                exp_be   = {be, exp_be[15:4]};
            end
            vregpack_op_pkg::PACK_NARROW_HOLD: begin
                exp_data = {d[15:0], exp_data[127:112], exp_data[95:0]};
                exp_be   = {be[1:0], exp_be[15:14], exp_be[11:0]};
            end
            vregpack_op_pkg::PACK_NARROW_SHIFT: begin
                exp_data = {d[15:0], exp_data[127:112], exp_data[127:32]};
                exp_be   = {be[1:0], exp_be[15:14], exp_be[15:4]};
            end
            default: ;
        endcase
    endtask

    // returns right after the edge that took the item
    task automatic send_result(vregpack_cfg_pkg::instr_id_t id, vregpack_cfg_pkg::vaddr_t addr,
                               vregpack_op_pkg::pack_op_e op, logic store, logic done,
                               logic clr = 1'b0, vregpack_cfg_pkg::pend_clr_cnt_t cnt = '0);
        vregpack_cfg_pkg::res_data_t d;
        vregpack_cfg_pkg::res_be_t   be;
        int n;
        d  = $urandom;
        be = 4'($urandom);
        n  = 0;
        @(posedge clk_i);
        pipe_in_valid_i        <= 1'b1;
        pipe_in_res_valid_i    <= 1'b1;
        pipe_in_instr_id_i     <= id;
        pipe_in_vaddr_i        <= addr;
        pipe_in_op_i           <= op;
        pipe_in_res_store_i    <= store;
        pipe_in_instr_done_i   <= done;
        pipe_in_pend_clr_i     <= clr;
        pipe_in_pend_clr_cnt_i <= cnt;
        res_data_i             <= d;
        res_be_i               <= be;
        @(negedge clk_i);
        while (!pipe_in_ready_o && n < 40) begin
            @(negedge clk_i);
            n++;
        end
        if (!pipe_in_ready_o) report_fault("timeout: input was never accepted");
        @(posedge clk_i);
        pipe_in_valid_i <= 1'b0;
        pack_model(op, d, be);
    endtask

    task automatic wait_write(vregpack_cfg_pkg::instr_id_t id, vregpack_cfg_pkg::vaddr_t addr,
                              string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!(vreg_wr_valid_o && vreg_wr_ready_i) && n < 40) begin
            @(negedge clk_i);
            n++;
        end
        if (vreg_wr_valid_o && vreg_wr_ready_i) begin
            check_addr("vreg_wr_addr_o", addr, vreg_wr_addr_o);
            check_data("vreg_wr_data_o", exp_data, vreg_wr_data_o);
            check_be("vreg_wr_be_o", exp_be, vreg_wr_be_o);
            if (instr_done_valid_o) check_id("instr_done_id_o", id, instr_done_id_o);
            else report_fault({"no done strobe with the register write after ", what});
        end else begin
            report_fault({"timeout: no register write after ", what});
        end
        @(posedge clk_i);
    endtask

    task automatic test_full_pack();
        for (int i = 0; i < 4; i++) begin
            send_result(3'd1, 5'd5, vregpack_op_pkg::PACK_FULL, i == 3, i == 3);
        end
        wait_write(3'd1, 5'd5, "full packing");
    endtask

    task automatic test_narrow_pack();
        for (int i = 0; i < 8; i++) begin
            send_result(3'd2, 5'd9, (i % 2) ? vregpack_op_pkg::PACK_NARROW_SHIFT :
                        vregpack_op_pkg::PACK_NARROW_HOLD, i == 7, i == 7);
        end
        wait_write(3'd2, 5'd9, "narrow packing");
    endtask

    task automatic test_stall();
        int w0, d0;
        for (int k = 0; k < 2; k++) begin
            @(posedge clk_i);
            if (k == 0) pending_vreg_reads_i <= 32'h1 << 7;  // readers on v7
            else instr_spec_i <= 8'h1 << 3;                 // ID 3 still speculative
            send_result(3'd3, 5'd7, vregpack_op_pkg::PACK_FULL, 1'b1, 1'b1);
            w0 = wr_cnt;
            d0 = done_cnt;
            repeat (20) @(negedge clk_i);
            @(posedge clk_i);
            if (wr_cnt != w0 || done_cnt != d0) report_fault("write or done while stalled");
            pending_vreg_reads_i <= '0;
            instr_spec_i         <= '0;
            wait_write(3'd3, 5'd7, "stall release");
        end
    endtask

    task automatic test_kill();
        int w0, n;
        n = 0;
        @(posedge clk_i);
        instr_killed_i <= 8'h1 << 4;
        w0 = wr_cnt;
        send_result(3'd4, 5'd11, vregpack_op_pkg::PACK_FULL, 1'b1, 1'b1);
        @(negedge clk_i);
        while (!instr_done_valid_o && n < 40) begin
            @(negedge clk_i);
            n++;
        end
        if (instr_done_valid_o) check_id("instr_done_id_o", 3'd4, instr_done_id_o);
        else report_fault("timeout: no done strobe for the killed item");
        @(posedge clk_i);
        instr_killed_i <= '0;
        if (wr_cnt != w0) report_fault("killed item reached the register file");
    endtask

    task automatic test_backpressure();
        int hold, w0;
        hold = $urandom_range(8, 1);
        @(posedge clk_i);
        vreg_wr_ready_i <= 1'b0;
        send_result(3'd5, 5'd20, vregpack_op_pkg::PACK_FULL, 1'b1, 1'b1);
        w0 = wr_cnt;
        repeat (hold) begin
            @(negedge clk_i);
            if (!vreg_wr_valid_o || pipe_in_ready_o) begin
                report_fault("handshake lost under back-pressure");
            end
            check_data("vreg_wr_data_o", exp_data, vreg_wr_data_o);
        end
        @(posedge clk_i);
        vreg_wr_ready_i <= 1'b1;
        wait_write(3'd5, 5'd20, "back-pressure release");
        repeat (4) @(posedge clk_i);
        if (wr_cnt != w0 + 1) report_fault("back-pressure gave other than one write");
    endtask

    task automatic test_pend_clear();
        vregpack_cfg_pkg::vaddr_t     addr;
        vregpack_cfg_pkg::vreg_mask_t expm;
        int seen;
        for (int c = 0; c < 4; c++) begin
            addr = 5'($urandom);
            seen = 0;
            for (int r = 0; r < 32; r++) begin
                expm[r] = (r >> c) == (addr >> c);  // same group above the low c bits
            end
            send_result(3'd6, addr, vregpack_op_pkg::PACK_NONE, 1'b0, 1'b1, 1'b1, 2'(c));
            repeat (8) begin
                @(negedge clk_i);
                if (clear_pending_vreg_writes_o != '0) begin
                    seen++;
                    check_mask("clear_pending_vreg_writes_o", expm, clear_pending_vreg_writes_o);
                end
            end
            if (seen != 1) report_fault("clear mask did not pulse exactly once");
        end
    endtask

    task automatic report_test(string name, int errs_before);
        test_cnt++;
        $display("test %-14s %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        void'($urandom(32'he7ea));
        async_rst_ni           = 1'b1;
        pipe_in_valid_i        = 1'b0;
        pipe_in_res_valid_i    = 1'b0;
        pipe_in_res_store_i    = 1'b0;
        pipe_in_pend_clr_i     = 1'b0;
        pipe_in_instr_done_i   = 1'b0;
        pipe_in_instr_id_i     = '0;
        pipe_in_vaddr_i        = '0;
        pipe_in_op_i           = vregpack_op_pkg::PACK_NONE;
        pipe_in_pend_clr_cnt_i = '0;
        res_data_i             = '0;
        res_be_i               = '0;
        pending_vreg_reads_i   = '0;
        instr_spec_i           = '0;
        instr_killed_i         = '0;
        vreg_wr_ready_i        = 1'b1;
        exp_data               = '0;  // buffer clears on reset
        exp_be                 = '0;
        #1 async_rst_ni = 1'b0;
        repeat (4) @(posedge clk_i);
        async_rst_ni <= 1'b1;

        e0 = err_cnt;
        test_full_pack();
        report_test("full_pack", e0);
        e0 = err_cnt;
        test_narrow_pack();
        report_test("narrow_pack", e0);
        e0 = err_cnt;
        test_stall();
        report_test("stall", e0);
        e0 = err_cnt;
        test_kill();
        report_test("kill", e0);
        e0 = err_cnt;
        test_backpressure();
        report_test("backpressure", e0);
        e0 = err_cnt;
        test_pend_clear();
        report_test("pend_clear", e0);

        repeat (2) @(posedge clk_i);
        $display("%0d tests, %0d errors, %0d assertion failures", test_cnt, err_cnt,
                 UUT.u_checker.fail_cnt);
        if (err_cnt == 0 && UUT.u_checker.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
src/vregpack_cfg_pkg.sv
src/vregpack_op_pkg.sv
src/vregpack_shift_buffer.sv
src/vregpack_stage.sv
src/vregpack_wr_port.sv
src/vregpack_top.sv
sim/vregpack_checker.sv
sim/vregpack_tb.sv

//--- Bender.yml
package:
  name: vregpack

sources:
  - src/vregpack_cfg_pkg.sv
  - src/vregpack_op_pkg.sv
  - src/vregpack_shift_buffer.sv
  - src/vregpack_stage.sv
  - src/vregpack_wr_port.sv
  - src/vregpack_top.sv
  - target: simulation
    files:
      - sim/vregpack_checker.sv
      - sim/vregpack_tb.sv
